// ==== logic/rec_pkg.sv ====
package rec_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Job requests
	////////////////////////////////////////////////////////////////////////////

	// Job codes as written by the processor
	typedef enum logic [2:0] {
		MODE_STOP      = 3'd0,
		MODE_PLAY      = 3'd1,
		MODE_RECORD    = 3'd2,
		MODE_ERASE     = 3'd3,
		MODE_ERASE_ALL = 3'd4
	} job_mode_e;

	// One-cycle start pulse with mode and target slot
	typedef struct packed {
		logic      start;
		job_mode_e mode;
		logic [2:0] slot;
	} job_req_t;

	////////////////////////////////////////////////////////////////////////////
	// Audio and slot state
	////////////////////////////////////////////////////////////////////////////

	// Signed 16-bit PCM sample
	typedef logic signed [15:0] sample_t;

	// Samples held by one slot
	typedef logic [7:0] len_t;

	typedef struct packed {
		logic occupied;
		len_t length;
	} slot_state_t;

	// Sequencer to tracker notifications
	typedef struct packed {
		logic sample_written;
		logic job_done;
	} seq_event_t;

	// Playback gain in eighths
	typedef logic [3:0] volume_t;

	localparam volume_t VOL_MIN   = 4'd1;
	localparam volume_t VOL_UNITY = 4'd8;
	localparam volume_t VOL_MAX   = 4'd15;

endpackage

// ==== logic/port_pkg.sv ====
package port_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Processor port bus
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] port_id;
		logic [7:0] out_port;
		logic       write_strobe;
		logic       read_strobe;
	} port_bus_t;

	// Job words in, status out
	localparam logic [7:0] PORT_JOB = 8'h0B;
	// Volume steps in, volume level out
	localparam logic [7:0] PORT_VOL = 8'h04;

	////////////////////////////////////////////////////////////////////////////
	// Control word views
	////////////////////////////////////////////////////////////////////////////

	// Mode in the top three bits, slot below it
	typedef struct packed {
		logic [2:0] mode;
		logic [2:0] slot;
		logic [1:0] reserved;
	} job_word_t;

	// Step flags in the top two bits
	typedef struct packed {
		logic       up;
		logic       down;
		logic [5:0] reserved;
	} vol_word_t;

	// Same out_port byte, view picked by port_id
	typedef union packed {
		job_word_t  job;
		vol_word_t  vol;
		logic [7:0] raw;
	} ctrl_word_u;

endpackage

// ==== logic/port_decoder.sv ====
module port_decoder #(
	parameter int NUM_SLOTS = 5
) (
	input  logic                  clk,
	input  logic                  pb_reset,
	input  port_pkg::port_bus_t   pb_bus,
	input  logic                  busy,
	input  rec_pkg::slot_state_t  slots [NUM_SLOTS],
	output rec_pkg::job_req_t     job,
	output rec_pkg::volume_t      volume,
	output logic [7:0]            in_port
);

	// Status byte has room for five occupancy bits
	localparam int SHOWN = (NUM_SLOTS < 5) ? NUM_SLOTS : 5;

	port_pkg::ctrl_word_u ctrl;
	rec_pkg::job_mode_e   req_mode;
	logic                 job_write;
	logic                 vol_write;
	logic                 mode_known;
	logic                 is_stop;
	logic                 slot_ok;
	logic                 accept;
	logic [4:0]           occ_bits;

	////////////////////////////////////////////////////////////////////////////
	// Write decode
	////////////////////////////////////////////////////////////////////////////

	assign ctrl.raw = pb_bus.out_port;
	assign req_mode = rec_pkg::job_mode_e'(ctrl.job.mode);

	assign job_write = pb_bus.write_strobe && (pb_bus.port_id == port_pkg::PORT_JOB);
	assign vol_write = pb_bus.write_strobe && (pb_bus.port_id == port_pkg::PORT_VOL);

	// Codes 5 to 7 are not jobs
	assign mode_known = (req_mode <= rec_pkg::MODE_ERASE_ALL);
	assign is_stop    = (req_mode == rec_pkg::MODE_STOP);
	// Stop and erase-all carry no slot
	assign slot_ok    = (int'(ctrl.job.slot) < NUM_SLOTS) || is_stop ||
		(req_mode == rec_pkg::MODE_ERASE_ALL);
	// Only stop may interrupt a running job
	assign accept     = job_write && mode_known && slot_ok && (!busy || is_stop);

	// Start pulse lasts one cycle
	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			job <= '0;
		end else begin
			job.start <= accept;
			if (accept) begin
				job.mode <= req_mode;
				job.slot <= ctrl.job.slot;
			end
		end
	end

	// Saturating volume, up has priority
	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			volume <= rec_pkg::VOL_UNITY;
		end else if (vol_write) begin
			if (ctrl.vol.up) begin
				if (volume < rec_pkg::VOL_MAX)
					volume <= volume + 1'b1;
			end else if (ctrl.vol.down) begin
				if (volume > rec_pkg::VOL_MIN)
					volume <= volume - 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////

	// Slot 0 in bit 0
	always_comb begin
		occ_bits = '0;
		for (int i = 0; i < SHOWN; i++)
			occ_bits[i] = slots[i].occupied;
	end

	// Registered on port_id alone, read_strobe does not matter
	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			in_port <= '0;
		end else begin
			case (pb_bus.port_id)
				port_pkg::PORT_JOB: in_port <= {busy, 2'b00, occ_bits};
				port_pkg::PORT_VOL: in_port <= {4'h0, volume};
				default:            in_port <= 8'h00;
			endcase
		end
	end

endmodule

// ==== logic/slot_tracker.sv ====
module slot_tracker #(
	parameter int SLOT_INDEX = 0,
	parameter int SLOT_DEPTH = 16
) (
	input  logic                  clk,
	input  logic                  pb_reset,
	input  rec_pkg::job_req_t     job,
	input  rec_pkg::seq_event_t   seq_event,
	output rec_pkg::slot_state_t  state
);

	// Set while this slot owns the running job
	logic active;
	logic is_mine;

	assign is_mine = (int'(job.slot) == SLOT_INDEX);

	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			active <= 1'b0;
			state  <= '0;
		end else begin
			if (job.start) begin
				case (job.mode)
					rec_pkg::MODE_PLAY: begin
						if (is_mine)
							active <= 1'b1;
					end
					// New take starts from empty
					rec_pkg::MODE_RECORD, rec_pkg::MODE_ERASE: begin
						if (is_mine) begin
							active <= 1'b1;
							state  <= '0;
						end
					end
					rec_pkg::MODE_ERASE_ALL: state <= '0;
					default: ;
				endcase
			end

			// Count written samples, never past the slot size
			if (active && seq_event.sample_written && (int'(state.length) < SLOT_DEPTH)) begin
				state.length   <= state.length + 1'b1;
				state.occupied <= 1'b1;
			end

			if (active && seq_event.job_done)
				active <= 1'b0;
		end
	end

endmodule

// ==== logic/sample_sequencer.sv ====
module sample_sequencer #(
	parameter int NUM_SLOTS  = 5,
	parameter int SLOT_DEPTH = 16
) (
	input  logic                                    clk,
	input  logic                                    pb_reset,
	input  rec_pkg::job_req_t                       job,
	input  rec_pkg::slot_state_t                    slots [NUM_SLOTS],
	input  rec_pkg::volume_t                        volume,
	output logic                                    busy,
	output rec_pkg::seq_event_t                     seq_event,
	output logic [$clog2(NUM_SLOTS*SLOT_DEPTH)-1:0] mem_addr,
	output logic                                    mem_we,
	output rec_pkg::sample_t                        mem_wdata,
	input  rec_pkg::sample_t                        mem_rdata,
	input  rec_pkg::sample_t                        audio_in,
	input  logic                                    audio_in_valid,
	output logic                                    audio_in_ready,
	output rec_pkg::sample_t                        audio_out,
	output logic                                    audio_out_valid,
	input  logic                                    audio_out_ready
);

	localparam int ADDR_W = $clog2(NUM_SLOTS * SLOT_DEPTH);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RECORD,
		S_PLAY,
		S_ERASE
	} seq_state_e;

	seq_state_e       state;
	logic [2:0]       slot_q;
	logic [ADDR_W-1:0] base_q;
	rec_pkg::len_t    offset;
	rec_pkg::len_t    play_len;
	logic             rd_pending;
	logic             out_valid;
	rec_pkg::sample_t out_data;
	logic             stop_req;
	logic             in_fire;
	logic             out_free;
	logic             rd_issue;
	logic             play_last;
	logic             job_done;

	// Gain in eighths, clipped to 16 bits
	function automatic rec_pkg::sample_t scale_sample(input rec_pkg::sample_t s,
		input rec_pkg::volume_t v);
		logic signed [20:0] prod;
		logic signed [20:0] shifted;
		begin
			prod    = s * $signed({1'b0, v});
			shifted = prod >>> 3;
			if (shifted > 21'sd32767)
				scale_sample = 16'sh7fff;
			else if (shifted < -21'sd32768)
				scale_sample = 16'sh8000;
			else
				scale_sample = shifted[15:0];
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Handshakes and end conditions
	////////////////////////////////////////////////////////////////////////////

	assign stop_req = job.start && (job.mode == rec_pkg::MODE_STOP);
	assign play_len = slots[slot_q].length;

	assign audio_in_ready = (state == S_RECORD);
	assign in_fire        = audio_in_ready && audio_in_valid;

	// Output register empty or emptying this cycle
	assign out_free  = !out_valid || audio_out_ready;
	// Single read in flight
	assign rd_issue  = (state == S_PLAY) && !rd_pending && out_free &&
		(offset < play_len) && !stop_req;
	// Also true at once for an empty slot
	assign play_last = !rd_pending && (offset == play_len) && out_free;

	always_comb begin
		case (state)
			S_RECORD: job_done = stop_req || (in_fire && (int'(offset) == SLOT_DEPTH - 1));
			S_PLAY:   job_done = stop_req || play_last;
			S_ERASE:  job_done = 1'b1;
			default:  job_done = 1'b0;
		endcase
	end

	assign busy                     = (state != S_IDLE);
	assign seq_event.sample_written = in_fire;
	assign seq_event.job_done       = job_done;

	// Memory port, writes straight from the input stream
	assign mem_addr  = base_q + ADDR_W'(offset);
	assign mem_we    = in_fire;
	assign mem_wdata = audio_in;

	assign audio_out       = out_data;
	assign audio_out_valid = out_valid;

	////////////////////////////////////////////////////////////////////////////
	// Job FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			state      <= S_IDLE;
			slot_q     <= '0;
			base_q     <= '0;
			offset     <= '0;
			rd_pending <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (job.start) begin
						slot_q     <= job.slot;
						// Slot base, fixed for the whole job
						base_q     <= ADDR_W'(int'(job.slot) * SLOT_DEPTH);
						offset     <= '0;
						rd_pending <= 1'b0;
						case (job.mode)
							rec_pkg::MODE_RECORD:    state <= S_RECORD;
							rec_pkg::MODE_PLAY:      state <= S_PLAY;
							rec_pkg::MODE_ERASE,
							rec_pkg::MODE_ERASE_ALL: state <= S_ERASE;
							default:                 state <= S_IDLE;
						endcase
					end
				end
				S_RECORD: begin
					if (in_fire)
						offset <= offset + 1'b1;
					if (job_done)
						state <= S_IDLE;
				end
				S_PLAY: begin
					if (rd_issue)
						offset <= offset + 1'b1;
					rd_pending <= rd_issue;
					// Data lands one cycle after the read
					if (rd_pending)
						out_valid <= 1'b1;
					else if (audio_out_ready)
						out_valid <= 1'b0;
					if (job_done) begin
						state      <= S_IDLE;
						rd_pending <= 1'b0;
						out_valid  <= 1'b0;
					end
				end
				// Slot lengths cleared by the trackers
				S_ERASE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Scaled output stage, holds while valid and not ready
	always_ff @(posedge clk) begin
		if (rd_pending)
			out_data <= scale_sample(mem_rdata, volume);
	end

endmodule

// ==== logic/sample_ram.sv ====
module sample_ram #(
	parameter int DEPTH = 80
) (
	input  logic                     clk,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic                     we,
	input  rec_pkg::sample_t         wdata,
	output rec_pkg::sample_t         rdata
);

	rec_pkg::sample_t mem [DEPTH];

	// Read returns the old word on a same-address write
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// ==== logic/recorder_top.sv ====
module recorder_top #(
	parameter int NUM_SLOTS  = 5,
	parameter int SLOT_DEPTH = 16
) (
	input  logic                 clk,
	input  logic                 pb_reset,
	input  port_pkg::port_bus_t  pb_bus,
	output logic [7:0]           in_port,
	input  rec_pkg::sample_t     audio_in,
	input  logic                 audio_in_valid,
	output logic                 audio_in_ready,
	output rec_pkg::sample_t     audio_out,
	output logic                 audio_out_valid,
	input  logic                 audio_out_ready
);

	localparam int DEPTH  = NUM_SLOTS * SLOT_DEPTH;
	localparam int ADDR_W = $clog2(DEPTH);

	rec_pkg::job_req_t    job;
	rec_pkg::volume_t     volume;
	rec_pkg::seq_event_t  seq_event;
	rec_pkg::slot_state_t slots [NUM_SLOTS];
	logic                 busy;
	logic [ADDR_W-1:0]    mem_addr;
	logic                 mem_we;
	rec_pkg::sample_t     mem_wdata;
	rec_pkg::sample_t     mem_rdata;

	// Processor ports to job pulses and volume
	port_decoder #(
		.NUM_SLOTS(NUM_SLOTS)
	) port_decoder_inst (
		.clk     (clk),
		.pb_reset(pb_reset),
		.pb_bus  (pb_bus),
		.busy    (busy),
		.slots   (slots),
		.job     (job),
		.volume  (volume),
		.in_port (in_port)
	);

	// One tracker per slot, all see the same job and events
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_slot
		slot_tracker #(
			.SLOT_INDEX(i),
			.SLOT_DEPTH(SLOT_DEPTH)
		) slot_tracker_inst (
			.clk      (clk),
			.pb_reset (pb_reset),
			.job      (job),
			.seq_event(seq_event),
			.state    (slots[i])
		);
	end

	sample_sequencer #(
		.NUM_SLOTS (NUM_SLOTS),
		.SLOT_DEPTH(SLOT_DEPTH)
	) sample_sequencer_inst (
		.clk            (clk),
		.pb_reset       (pb_reset),
		.job            (job),
		.slots          (slots),
		.volume         (volume),
		.busy           (busy),
		.seq_event      (seq_event),
		.mem_addr       (mem_addr),
		.mem_we         (mem_we),
		.mem_wdata      (mem_wdata),
		.mem_rdata      (mem_rdata),
		.audio_in       (audio_in),
		.audio_in_valid (audio_in_valid),
		.audio_in_ready (audio_in_ready),
		.audio_out      (audio_out),
		.audio_out_valid(audio_out_valid),
		.audio_out_ready(audio_out_ready)
	);

	// All slots share one memory
	sample_ram #(
		.DEPTH(DEPTH)
	) sample_ram_inst (
		.clk  (clk),
		.addr (mem_addr),
		.we   (mem_we),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

// ==== tb/recorder_assert.sv ====
module recorder_assert (
	input  logic              clk,
	input  logic              pb_reset,
	input  rec_pkg::job_req_t job,
	input  logic              busy,
	input  logic              job_done,
	input  logic              audio_in_ready,
	input  rec_pkg::sample_t  audio_out,
	input  logic              audio_out_valid,
	input  logic              audio_out_ready
);

	// Failed assertions, summed into the final count
	int fail_count = 0;

	// Input stream opens only on the edge after a record job start
	ready_opens_on_record: assert property (@(posedge clk) disable iff (pb_reset)
		$rose(audio_in_ready) |-> $past(job.start && job.mode == rec_pkg::MODE_RECORD))
		else begin
			$error("audio_in_ready rose without a record job start");
			fail_count++;
		end

	// Input stream closes once the job is over
	ready_closes_on_done: assert property (@(posedge clk) disable iff (pb_reset)
		job_done |=> !audio_in_ready)
		else begin
			$error("audio_in_ready still high after job_done");
			fail_count++;
		end

	// Stalled output word must not move
	out_held: assert property (@(posedge clk) disable iff (pb_reset)
		audio_out_valid && !audio_out_ready |=> audio_out_valid && $stable(audio_out))
		else begin
			$error("audio_out changed or dropped valid while stalled");
			fail_count++;
		end

	// Job ends one edge after its done event
	busy_after_done: assert property (@(posedge clk) disable iff (pb_reset)
		$fell(busy) |-> $past(job_done))
		else begin
			$error("busy fell without job_done in the cycle before");
			fail_count++;
		end

endmodule

// ==== tb/recorder_checker.sv ====
module recorder_checker #(
	parameter int NUM_SLOTS  = 5,
	parameter int SLOT_DEPTH = 16
) (
	input  logic                clk,
	input  logic                pb_reset,
	input  port_pkg::port_bus_t pb_bus,
	input  logic [7:0]          in_port,
	input  rec_pkg::sample_t    audio_in,
	input  logic                audio_in_valid,
	input  logic                audio_in_ready,
	input  rec_pkg::sample_t    audio_out,
	input  logic                audio_out_valid,
	input  logic                audio_out_ready,
	output int                  errors,
	output int                  checks,
	output int                  pending
);

	// Expected slot contents, filled from input transfers
	rec_pkg::sample_t mirror [NUM_SLOTS][SLOT_DEPTH];
	int               mlen [NUM_SLOTS];
	// Scaled samples still owed by the running playback
	rec_pkg::sample_t exp_q [$];
	rec_pkg::sample_t exp_val;
	int               vol;
	int               rec_slot;
	logic             recording;
	logic             model_busy;
	logic             job_seen;
	logic             rd_pend;
	logic [7:0]       rd_exp;
	logic [7:0]       rd_mask;
	logic [2:0]       mode;
	logic [2:0]       slot;
	logic             accept;

	// Gain in eighths with floor shift, clipped to 16 bits
	function automatic rec_pkg::sample_t scaled_sample(input rec_pkg::sample_t s, input int v);
		int p;
		p = (int'(s) * v) >>> 3;
		if (p > 32767)
			return 16'sh7fff;
		if (p < -32768)
			return 16'sh8000;
		return 16'(p);
	endfunction

	always @(posedge clk) begin
		if (pb_reset) begin
			for (int i = 0; i < NUM_SLOTS; i++)
				mlen[i] = 0;
			exp_q.delete();
			vol        = 8;
			rec_slot   = 0;
			recording  = 1'b0;
			model_busy = 1'b0;
			job_seen   = 1'b0;
			rd_pend    = 1'b0;
			errors     = 0;
			checks     = 0;
			pending    = 0;
		end else begin
			////////////////////////////////////////////////////////////////////////////
			// Port reads, result one cycle after the strobe
			////////////////////////////////////////////////////////////////////////////
			if (rd_pend) begin
				checks++;
				if ((in_port & rd_mask) !== rd_exp) begin
					$display("ERR in_port: expected %h, got %h", rd_exp, in_port & rd_mask);
					errors++;
				end
			end
			rd_pend = pb_bus.read_strobe;
			if (pb_bus.read_strobe) begin
				rd_mask = 8'hff;
				rd_exp  = 8'h00;
				// Busy bit known low until the first job write
				if (pb_bus.port_id == port_pkg::PORT_JOB) begin
					rd_mask = job_seen ? 8'h1f : 8'hff;
					for (int i = 0; i < NUM_SLOTS && i < 5; i++)
						rd_exp[i] = (mlen[i] != 0);
				end else if (pb_bus.port_id == port_pkg::PORT_VOL) begin
					rd_exp = 8'(vol);
				end
			end

			////////////////////////////////////////////////////////////////////////////
			// Audio streams
			////////////////////////////////////////////////////////////////////////////
			if (audio_out_valid && audio_out_ready) begin
				if (exp_q.size() == 0) begin
					$display("Output sample %h appeared with nothing left to play", audio_out);
					errors++;
				end else begin
					exp_val = exp_q.pop_front();
					checks++;
					if (audio_out !== exp_val) begin
						$display("ERR audio_out: expected %h, got %h", exp_val, audio_out);
						errors++;
					end
					if (exp_q.size() == 0)
						model_busy = 1'b0;
				end
			end
			if (audio_in_valid && audio_in_ready) begin
				if (!recording) begin
					$display("Input sample taken while no recording was running");
					errors++;
				end else begin
					mirror[rec_slot][mlen[rec_slot]] = audio_in;
					mlen[rec_slot]++;
					// Full slot ends the take
					if (mlen[rec_slot] == SLOT_DEPTH) begin
						recording  = 1'b0;
						model_busy = 1'b0;
					end
				end
			end

			////////////////////////////////////////////////////////////////////////////
			// Port writes
			////////////////////////////////////////////////////////////////////////////
			if (pb_bus.write_strobe && pb_bus.port_id == port_pkg::PORT_VOL) begin
				// Up wins over down
				if (pb_bus.out_port[7]) begin
					if (vol < 15)
						vol++;
				end else if (pb_bus.out_port[6]) begin
					if (vol > 1)
						vol--;
				end
			end
			if (pb_bus.write_strobe && pb_bus.port_id == port_pkg::PORT_JOB) begin
				job_seen = 1'b1;
				mode     = pb_bus.out_port[7:5];
				slot     = pb_bus.out_port[4:2];
				accept   = (mode <= rec_pkg::MODE_ERASE_ALL) &&
					(!model_busy || mode == rec_pkg::MODE_STOP) &&
					(slot < NUM_SLOTS || mode == rec_pkg::MODE_STOP ||
					mode == rec_pkg::MODE_ERASE_ALL);
				if (accept) begin
					case (mode)
						rec_pkg::MODE_STOP: begin
							recording  = 1'b0;
							model_busy = 1'b0;
							exp_q.delete();
						end
						// Volume fixed for the whole playback
						rec_pkg::MODE_PLAY: begin
							for (int k = 0; k < mlen[slot]; k++)
								exp_q.push_back(scaled_sample(mirror[slot][k], vol));
							model_busy = (mlen[slot] != 0);
						end
						rec_pkg::MODE_RECORD: begin
							mlen[slot] = 0;
							rec_slot   = slot;
							recording  = 1'b1;
							model_busy = 1'b1;
						end
						rec_pkg::MODE_ERASE: mlen[slot] = 0;
						rec_pkg::MODE_ERASE_ALL: begin
							for (int i = 0; i < NUM_SLOTS; i++)
								mlen[i] = 0;
						end
						default: ;
					endcase
				end
			end
			pending = exp_q.size();
		end
	end

endmodule

// ==== tb/recorder_tb.sv ====
module recorder_tb;

	localparam int NUM_SLOTS    = 5;
	localparam int SLOT_DEPTH   = 16;
	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	// Three playbacks under back-pressure plus bus traffic per test
	localparam int TEST_CYCLES     = 3 * SLOT_DEPTH * 8 + 400;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 5 * TEST_CYCLES + 1000;

	logic                clk             = 1'b0;
	logic                pb_reset        = 1'b1;
	port_pkg::port_bus_t pb_bus          = '0;
	rec_pkg::sample_t    audio_in        = '0;
	logic                audio_in_valid  = 1'b0;
	logic                audio_out_ready = 1'b1;
	logic [7:0]          in_port;
	logic                audio_in_ready;
	rec_pkg::sample_t    audio_out;
	logic                audio_out_valid;

	// Precomputed ready pattern, 1 in 4 cycles stalls
	logic                bp_on  = 1'b0;
	logic [255:0]        bp_pattern;
	logic [7:0]          bp_idx = '0;
	int                  tb_fails = 0;
	int                  chk_errors;
	int                  chk_checks;
	int                  chk_pending;
	int                  sent;
	logic [7:0]          rd_val;

	always #(CLK_PERIOD / 2) clk = ~clk;

	recorder_top #(
		.NUM_SLOTS (NUM_SLOTS),
		.SLOT_DEPTH(SLOT_DEPTH)
	) recorder_top_inst (
		.clk            (clk),
		.pb_reset       (pb_reset),
		.pb_bus         (pb_bus),
		.in_port        (in_port),
		.audio_in       (audio_in),
		.audio_in_valid (audio_in_valid),
		.audio_in_ready (audio_in_ready),
		.audio_out      (audio_out),
		.audio_out_valid(audio_out_valid),
		.audio_out_ready(audio_out_ready)
	);

	recorder_checker #(
		.NUM_SLOTS (NUM_SLOTS),
		.SLOT_DEPTH(SLOT_DEPTH)
	) recorder_checker_inst (
		.clk            (clk),
		.pb_reset       (pb_reset),
		.pb_bus         (pb_bus),
		.in_port        (in_port),
		.audio_in       (audio_in),
		.audio_in_valid (audio_in_valid),
		.audio_in_ready (audio_in_ready),
		.audio_out      (audio_out),
		.audio_out_valid(audio_out_valid),
		.audio_out_ready(audio_out_ready),
		.errors         (chk_errors),
		.checks         (chk_checks),
		.pending        (chk_pending)
	);

	bind sample_sequencer recorder_assert recorder_assert_inst (
		.clk            (clk),
		.pb_reset       (pb_reset),
		.job            (job),
		.busy           (busy),
		.job_done       (seq_event.job_done),
		.audio_in_ready (audio_in_ready),
		.audio_out      (audio_out),
		.audio_out_valid(audio_out_valid),
		.audio_out_ready(audio_out_ready)
	);

	// Output back-pressure, changes just after each edge
	always @(posedge clk) begin
		#1;
		audio_out_ready = bp_on ? bp_pattern[bp_idx] : 1'b1;
		bp_idx = bp_idx + 1'b1;
	end

	function automatic int total_errors();
		return chk_errors + tb_fails +
			recorder_top_inst.sample_sequencer_inst.recorder_assert_inst.fail_count;
	endfunction

	// Mode in bits 7:5, slot in bits 4:2
	function automatic logic [7:0] job_word(input rec_pkg::job_mode_e mode, input int slot);
		return {mode, 3'(slot), 2'b00};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus and stream tasks, all start and end 1 unit after an edge
	////////////////////////////////////////////////////////////////////////////

	task automatic write_port(input logic [7:0] id, input logic [7:0] data);
		pb_bus.port_id      = id;
		pb_bus.out_port     = data;
		pb_bus.write_strobe = 1'b1;
		@(posedge clk);
		#1;
		pb_bus.write_strobe = 1'b0;
	endtask

	// Idle cycle first so a preceding write has settled
	task automatic read_port(input logic [7:0] id, output logic [7:0] value);
		@(posedge clk);
		#1;
		pb_bus.port_id     = id;
		pb_bus.read_strobe = 1'b1;
		@(posedge clk);
		#1;
		pb_bus.read_strobe = 1'b0;
		value = in_port;
	endtask

	// Poll status bit 7 until the job is over
	task automatic wait_idle(input string what);
		logic [7:0] status;
		int         polls;
		status = 8'h80;
		polls  = 0;
		while (status[7] && polls < 200) begin
			read_port(port_pkg::PORT_JOB, status);
			polls++;
		end
		if (status[7]) begin
			$display("Busy flag never cleared after %s", what);
			tb_fails++;
		end
	endtask

	task automatic play_slot(input int slot);
		write_port(port_pkg::PORT_JOB, job_word(rec_pkg::MODE_PLAY, slot));
		wait_idle("play");
		if (chk_pending != 0) begin
			$display("Playback of slot %0d ended with %0d samples missing", slot, chk_pending);
			tb_fails++;
		end
	endtask

	// Offers up to n samples, gives up once ready falls after a transfer
	task automatic send_samples(input int n, output int count);
		logic rdy;
		logic ended;
		int   idle;
		count = 0;
		ended = 1'b0;
		idle  = 0;
		audio_in       = rec_pkg::sample_t'($urandom);
		audio_in_valid = 1'b1;
		while (count < n && !ended && idle < 50) begin
			rdy = audio_in_ready;
			@(posedge clk);
			#1;
			if (rdy) begin
				count++;
				idle     = 0;
				audio_in = rec_pkg::sample_t'($urandom);
			end else if (count > 0) begin
				ended = 1'b1;
			end else begin
				idle++;
			end
		end
		audio_in_valid = 1'b0;
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d (%s) finished, %0d errors so far", num, name, total_errors());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h4304_fad6));
		for (int i = 0; i < 256; i++)
			bp_pattern[i] = (($urandom % 4) != 0);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		pb_reset = 1'b0;

		// Clean state after reset
		read_port(port_pkg::PORT_JOB, rd_val);
		read_port(port_pkg::PORT_VOL, rd_val);
		end_test(1, "reset state");

		// Short take with stop, then unity playback
		write_port(port_pkg::PORT_JOB, job_word(rec_pkg::MODE_RECORD, 2));
		send_samples(12, sent);
		if (sent != 12) begin
			$display("Slot 2 took %0d samples, 12 were offered", sent);
			tb_fails++;
		end
		write_port(port_pkg::PORT_JOB, job_word(rec_pkg::MODE_STOP, 0));
		wait_idle("stop");
		read_port(port_pkg::PORT_JOB, rd_val);
		bp_on = 1'b1;
		play_slot(2);
		end_test(2, "record and play at unity");

		// Volume clamps at both ends
		repeat (10) write_port(port_pkg::PORT_VOL, 8'h80);
		read_port(port_pkg::PORT_VOL, rd_val);
		repeat (20) write_port(port_pkg::PORT_VOL, 8'h40);
		read_port(port_pkg::PORT_VOL, rd_val);
		repeat (14) write_port(port_pkg::PORT_VOL, 8'h80);
		play_slot(2);
		repeat (12) write_port(port_pkg::PORT_VOL, 8'h40);
		read_port(port_pkg::PORT_VOL, rd_val);
		play_slot(2);
		end_test(3, "volume saturation and scaling");

		// Fill slot 4, a play request mid-take must be dropped
		write_port(port_pkg::PORT_JOB, job_word(rec_pkg::MODE_RECORD, 4));
		fork
			send_samples(SLOT_DEPTH + 4, sent);
			begin
				repeat (4) @(posedge clk);
				#1;
				write_port(port_pkg::PORT_JOB, job_word(rec_pkg::MODE_PLAY, 2));
			end
		join
		if (sent != SLOT_DEPTH) begin
			$display("Ready fell after %0d transfers instead of %0d", sent, SLOT_DEPTH);
			tb_fails++;
		end
		wait_idle("full record");
		play_slot(4);
		play_slot(2);
		end_test(4, "record to full slot");

		// Single erase, empty playback, then erase all
		write_port(port_pkg::PORT_JOB, job_word(rec_pkg::MODE_ERASE, 2));
		wait_idle("erase");
		read_port(port_pkg::PORT_JOB, rd_val);
		play_slot(2);
		write_port(port_pkg::PORT_JOB, job_word(rec_pkg::MODE_ERASE_ALL, 0));
		wait_idle("erase all");
		read_port(port_pkg::PORT_JOB, rd_val);
		end_test(5, "erase");

		$display("Done: 5 tests, %0d checks, %0d errors", chk_checks, total_errors());
		if (total_errors() == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Hard stop if a test hangs
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
logic/rec_pkg.sv
logic/port_pkg.sv
logic/port_decoder.sv
logic/slot_tracker.sv
logic/sample_sequencer.sv
logic/sample_ram.sv
logic/recorder_top.sv
tb/recorder_assert.sv
tb/recorder_checker.sv
tb/recorder_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the recorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module recorder_tb -Mdir obj_dir -o recorder_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/recorder_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
	exit 0
fi
echo "Simulation reported failure"
exit 1
